//--- rtl/dfd_csr_regs.sv
`timescale 1ns/1ps

module dfd_csr_regs
  import dfd_pkg::*;
(
  input  logic                         clk,
  input  logic                         i_reset,

  // APB slave
  input  logic [APB_ADDR_WIDTH-1:0]    i_paddr,
  input  logic                         i_psel,
  input  logic                         i_penable,
  input  logic                         i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0]    i_pwdata,
  output logic                         o_pready,
  output logic [APB_DATA_WIDTH-1:0]    o_prdata,
  output logic                         o_pslverr,

  // Stage config and buffer read-back
  output traceCfg_t                    o_cfg,
  output logic [TRACE_INDEX_WIDTH-1:0] o_readIdx,
  input  traceEntry_t                  i_readEntry,
  input  sinkStatus_t                  i_status
);

  regAddr_e                     addr;
  logic                         access;
  logic                         mapped;
  logic                         readOnly;
  logic                         wrEn;
  traceCfg_t                    cfgReg;
  logic [TRACE_INDEX_WIDTH-1:0] readIdxReg;

  assign addr   = regAddr_e'(i_paddr);
  assign access = i_psel & i_penable;

  // **************************************************
  // Decode and read mux
  // **************************************************
  always_comb begin
    mapped   = 1'b1;
    readOnly = 1'b0;
    o_prdata = '0;
    case (addr)
      REG_CTRL: begin
        // Clear bit always reads back zero
        o_prdata[0] = cfgReg.enable;
        o_prdata[1] = cfgReg.captureMode;
        o_prdata[2] = cfgReg.wrapEn;
      end
      REG_MUXSEL: begin
        o_prdata[3:0] = cfgReg.selLow;
        o_prdata[7:4] = cfgReg.selHigh;
      end
      REG_STATUS: begin
        readOnly                      = 1'b1;
        o_prdata[TRACE_INDEX_WIDTH:0] = i_status.fillCount;
        o_prdata[8]                   = i_status.wrapped;
      end
      REG_READIDX: begin
        o_prdata[TRACE_INDEX_WIDTH-1:0] = readIdxReg;
      end
      REG_READDATA: begin
        readOnly = 1'b1;
        o_prdata = i_readEntry.data;
      end
      REG_READTIME: begin
        // Bit 16 flags an index inside the filled range
        readOnly                          = 1'b1;
        o_prdata[TIMESTAMP_WIDTH-1:0]     = i_readEntry.timestamp;
        o_prdata[TIMESTAMP_WIDTH]         = i_readEntry.valid;
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  assign wrEn      = access & i_pwrite & mapped & ~readOnly;
  assign o_pslverr = access & (~mapped | (i_pwrite & readOnly));
  assign o_pready  = 1'b1;

  // **************************************************
  // Writable registers
  // **************************************************
  always_ff @(posedge clk) begin
    if (i_reset) begin
      cfgReg     <= '0;
      readIdxReg <= '0;
    end else begin
      cfgReg.clear <= 1'b0;
      if (wrEn) begin
        case (addr)
          REG_CTRL: begin
            cfgReg.enable      <= i_pwdata[0];
            cfgReg.captureMode <= captureMode_e'(i_pwdata[1]);
            cfgReg.wrapEn      <= i_pwdata[2];
            cfgReg.clear       <= i_pwdata[3];
          end
          REG_MUXSEL: begin
            cfgReg.selLow  <= i_pwdata[3:0];
            cfgReg.selHigh <= i_pwdata[7:4];
          end
          REG_READIDX: begin
            readIdxReg <= i_pwdata[TRACE_INDEX_WIDTH-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign o_cfg     = cfgReg;
  assign o_readIdx = readIdxReg;

endmodule

//--- rtl/dfd_debug_mux.sv
`timescale 1ns/1ps

module dfd_debug_mux
  import dfd_pkg::*;
(
  input  logic         clk,
  input  logic         i_reset,
  input  hwGroups_t    i_hwGroups,
  input  logic         i_traceStart,
  input  logic         i_traceStop,
  input  logic         i_tracePulse,
  input  traceCfg_t    i_cfg,
  output debugSample_t o_sample
);

  logic [DEBUG_BUS_WIDTH-1:0] busSel;
  traceAction_t               actionIn;

  // High group in the upper half of the bus
  assign busSel = {i_hwGroups[i_cfg.selHigh], i_hwGroups[i_cfg.selLow]};

  assign actionIn.start = i_traceStart;
  assign actionIn.stop  = i_traceStop;
  assign actionIn.pulse = i_tracePulse;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_sample.valid <= 1'b0;
    end else begin
      o_sample.valid <= 1'b1;
    end
  end

  // Actions registered with the bus so both reach the controller together
  always_ff @(posedge clk) begin
    o_sample.bus    <= busSel;
    o_sample.action <= actionIn;
  end

endmodule

//--- rtl/dfd_packetizer.sv
`timescale 1ns/1ps

module dfd_packetizer
  import dfd_pkg::*;
(
  input  logic        clk,
  input  logic        i_reset,
  input  logic        i_timeTick,
  input  traceEntry_t i_entry,
  output traceEntry_t o_entry
);

  logic [TIMESTAMP_WIDTH-1:0] tickCount;

  // Free running tick count that wraps at 2^16
  always_ff @(posedge clk) begin
    if (i_reset) begin
      tickCount <= '0;
    end else if (i_timeTick) begin
      tickCount <= tickCount + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_entry.valid <= 1'b0;
    end else begin
      o_entry.valid <= i_entry.valid;
    end
  end

  // Stamp with ticks seen before this edge
  always_ff @(posedge clk) begin
    o_entry.data      <= i_entry.data;
    o_entry.timestamp <= tickCount;
  end

endmodule

//--- rtl/dfd_pkg.sv
package dfd_pkg;

  // **************************************************
  // Sizes
  // **************************************************
  localparam int HW_GROUPS         = 16;
  localparam int HW_GROUP_WIDTH    = 16;
  localparam int DEBUG_BUS_WIDTH   = 32;
  localparam int TIMESTAMP_WIDTH   = 16;
  localparam int TRACE_DEPTH       = 64;
  localparam int TRACE_INDEX_WIDTH = 6;
  localparam int APB_ADDR_WIDTH    = 8;
  localparam int APB_DATA_WIDTH    = 32;

  // **************************************************
  // Types
  // **************************************************
  typedef logic [HW_GROUPS-1:0][HW_GROUP_WIDTH-1:0] hwGroups_t;

  typedef struct packed {
    logic start;
    logic stop;
    logic pulse;
  } traceAction_t;

  typedef enum logic {
    CAPTURE_ALL    = 1'b0,
    CAPTURE_CHANGE = 1'b1
  } captureMode_e;

  typedef enum logic {
    TRACE_IDLE = 1'b0,
    TRACE_RUN  = 1'b1
  } traceState_e;

  // APB register offsets
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL     = 8'h00,
    REG_MUXSEL   = 8'h04,
    REG_STATUS   = 8'h08,
    REG_READIDX  = 8'h0C,
    REG_READDATA = 8'h10,
    REG_READTIME = 8'h14
  } regAddr_e;

  typedef struct packed {
    logic         enable;
    captureMode_e captureMode;
    logic         wrapEn;
    logic         clear;
    logic [3:0]   selLow;
    logic [3:0]   selHigh;
  } traceCfg_t;

  typedef struct packed {
    logic                       valid;
    logic [DEBUG_BUS_WIDTH-1:0] bus;
    traceAction_t               action;
  } debugSample_t;

  typedef struct packed {
    logic                       valid;
    logic [TIMESTAMP_WIDTH-1:0] timestamp;
    logic [DEBUG_BUS_WIDTH-1:0] data;
  } traceEntry_t;

  typedef struct packed {
    logic [TRACE_INDEX_WIDTH:0] fillCount;
    logic                       wrapped;
  } sinkStatus_t;

endpackage

//--- rtl/dfd_top.sv
`timescale 1ns/1ps

module dfd_top
  import dfd_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_reset,

  // Debug sources and trace actions
  input  hwGroups_t                 i_hwGroups,
  input  logic                      i_traceStart,
  input  logic                      i_traceStop,
  input  logic                      i_tracePulse,
  input  logic                      i_timeTick,

  // APB slave
  input  logic [APB_ADDR_WIDTH-1:0] i_paddr,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0] i_pwdata,
  output logic                      o_pready,
  output logic [APB_DATA_WIDTH-1:0] o_prdata,
  output logic                      o_pslverr
);

  traceCfg_t                    cfg;
  logic [TRACE_INDEX_WIDTH-1:0] readIdx;
  traceEntry_t                  readEntry;
  sinkStatus_t                  status;
  debugSample_t                 sample;
  traceEntry_t                  ctrlEntry;
  traceEntry_t                  pktEntry;

  dfd_csr_regs u_csrRegs (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_paddr     (i_paddr),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_pwdata    (i_pwdata),
    .o_pready    (o_pready),
    .o_prdata    (o_prdata),
    .o_pslverr   (o_pslverr),
    .o_cfg       (cfg),
    .o_readIdx   (readIdx),
    .i_readEntry (readEntry),
    .i_status    (status)
  );

  // **************************************************
  // Trace pipeline from the mux through ctrl and packetizer to the sink
  // **************************************************
  dfd_debug_mux u_debugMux (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_hwGroups   (i_hwGroups),
    .i_traceStart (i_traceStart),
    .i_traceStop  (i_traceStop),
    .i_tracePulse (i_tracePulse),
    .i_cfg        (cfg),
    .o_sample     (sample)
  );

  dfd_trace_ctrl u_traceCtrl (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_cfg    (cfg),
    .i_sample (sample),
    .o_entry  (ctrlEntry)
  );

  dfd_packetizer u_packetizer (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_timeTick (i_timeTick),
    .i_entry    (ctrlEntry),
    .o_entry    (pktEntry)
  );

  dfd_trace_sink u_traceSink (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_cfg       (cfg),
    .i_entry     (pktEntry),
    .i_readIdx   (readIdx),
    .o_readEntry (readEntry),
    .o_status    (status)
  );

endmodule

//--- rtl/dfd_trace_ctrl.sv
`timescale 1ns/1ps

module dfd_trace_ctrl
  import dfd_pkg::*;
(
  input  logic         clk,
  input  logic         i_reset,
  input  traceCfg_t    i_cfg,
  input  debugSample_t i_sample,
  output traceEntry_t  o_entry
);

  traceState_e                state;
  traceState_e                stateNext;
  traceAction_t               act;
  logic [DEBUG_BUS_WIDTH-1:0] lastBus;
  logic                       haveLast;
  logic                       wasRun;
  logic                       trigHit;
  logic                       changed;
  logic                       capture;

  assign act    = i_sample.action;
  assign wasRun = (state == TRACE_RUN);

  // Stop beats start
  always_comb begin
    stateNext = state;
    if (act.stop) begin
      stateNext = TRACE_IDLE;
    end else if (act.start) begin
      stateNext = TRACE_RUN;
    end
  end

  // **************************************************
  // Capture decision
  // **************************************************
  assign trigHit = i_cfg.enable &
                   ((wasRun & ~act.stop) | (act.start & ~act.stop) | act.pulse);

  // First sample after reset or clear always counts as a change
  assign changed = ~haveLast | (i_sample.bus != lastBus);

  assign capture = i_sample.valid & trigHit &
                   ((i_cfg.captureMode == CAPTURE_ALL) | changed);

  always_ff @(posedge clk) begin
    if (i_reset || i_cfg.clear) begin
      state         <= TRACE_IDLE;
      haveLast      <= 1'b0;
      o_entry.valid <= 1'b0;
    end else begin
      o_entry.valid <= capture;
      if (i_sample.valid) begin
        state <= stateNext;
      end
      if (capture) begin
        haveLast <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    o_entry.data      <= i_sample.bus;
    o_entry.timestamp <= '0;
    if (capture) begin
      lastBus <= i_sample.bus;
    end
  end

endmodule

//--- rtl/dfd_trace_sink.sv
`timescale 1ns/1ps

module dfd_trace_sink
  import dfd_pkg::*;
(
  input  logic                         clk,
  input  logic                         i_reset,
  input  traceCfg_t                    i_cfg,
  input  traceEntry_t                  i_entry,
  input  logic [TRACE_INDEX_WIDTH-1:0] i_readIdx,
  output traceEntry_t                  o_readEntry,
  output sinkStatus_t                  o_status
);

  logic [TIMESTAMP_WIDTH+DEBUG_BUS_WIDTH-1:0] traceMem [TRACE_DEPTH];

  logic [TRACE_INDEX_WIDTH-1:0] wrPtr;
  logic [TRACE_INDEX_WIDTH-1:0] rdAddr;
  logic [TRACE_INDEX_WIDTH:0]   fillCount;
  logic                         wrapped;
  logic                         full;
  logic                         wrEn;

  assign full = (fillCount == (TRACE_INDEX_WIDTH + 1)'(TRACE_DEPTH));

  // Without wrap a full buffer drops new entries
  assign wrEn = i_entry.valid & ~i_cfg.clear & (~full | i_cfg.wrapEn);

  // **************************************************
  // Pointer, count and wrap flag
  // **************************************************
  always_ff @(posedge clk) begin
    if (i_reset || i_cfg.clear) begin
      wrPtr     <= '0;
      fillCount <= '0;
      wrapped   <= 1'b0;
    end else if (wrEn) begin
      wrPtr <= wrPtr + 1'b1;
      if (full) begin
        wrapped <= 1'b1;
      end else begin
        fillCount <= fillCount + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      traceMem[wrPtr] <= {i_entry.timestamp, i_entry.data};
    end
  end

  // **************************************************
  // Read-back with index 0 as the oldest entry
  // **************************************************
  assign rdAddr = wrapped ? (wrPtr + i_readIdx) : i_readIdx;

  assign o_readEntry.valid = ({1'b0, i_readIdx} < fillCount);
  assign {o_readEntry.timestamp, o_readEntry.data} = traceMem[rdAddr];

  assign o_status.fillCount = fillCount;
  assign o_status.wrapped   = wrapped;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the trace block testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f vlog.f --top-module dfd_tb -o dfd_sim; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/dfd_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

//--- tb/dfd_tb.sv
`timescale 1ns/1ps

module dfd_tb
  import dfd_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int FLUSH_CYCLES    = 4;
  localparam int RANDOM_CYCLES   = 120;
  localparam int FILL_SAMPLES    = 80;
  localparam int DISABLED_CYCLES = 40;
  localparam int READBACK_CYCLES = 2 + 6 * TRACE_DEPTH;
  localparam int DRIVE_CYCLES    = 2 * RANDOM_CYCLES + 2 * FILL_SAMPLES + DISABLED_CYCLES;
  localparam int TIMEOUT_CYCLES  = 2 * (DRIVE_CYCLES + 5 * READBACK_CYCLES + 200);

  logic                      clk;
  logic                      reset;
  hwGroups_t                 hwGroups;
  logic                      traceStart;
  logic                      traceStop;
  logic                      tracePulse;
  logic                      timeTick;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic                      pready;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pslverr;

  // Reference model state
  int          errors;
  int          tickTotal;
  logic [31:0] expData[$];
  logic        mEnable;
  logic        mChange;
  logic        mWrap;
  logic        mRun;
  logic        mHaveLast;
  logic [31:0] mLastBus;
  logic [3:0]  mSelLow;
  logic [3:0]  mSelHigh;

  dfd_top dut (
    .clk          (clk),
    .i_reset      (reset),
    .i_hwGroups   (hwGroups),
    .i_traceStart (traceStart),
    .i_traceStop  (traceStop),
    .i_tracePulse (tracePulse),
    .i_timeTick   (timeTick),
    .i_paddr      (paddr),
    .i_psel       (psel),
    .i_penable    (penable),
    .i_pwrite     (pwrite),
    .i_pwdata     (pwdata),
    .o_pready     (pready),
    .o_prdata     (prdata),
    .o_pslverr    (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // **************************************************
  // APB access started 10 ns after a rising edge
  // **************************************************
  task automatic apbAccess(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #40;
    rdata = prdata;
    err   = pslverr;
    checkValue("apb pready", 32'd1, {31'b0, pready});
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  function automatic hwGroups_t randomGroups(input logic smallSet);
    hwGroups_t groups;
    for (int i = 0; i < HW_GROUPS; i++) begin
      if (smallSet) begin
        groups[i] = (($urandom % 2) == 0) ? 16'h0000 : 16'hC3A5;
      end else begin
        groups[i] = 16'($urandom);
      end
    end
    return groups;
  endfunction

  // One driven cycle where the model sees the same inputs as the mux
  task automatic driveCycle(input hwGroups_t groups, input logic start, input logic stop,
                            input logic pulse);
    logic [31:0] bus;
    logic        cap;
    hwGroups   = groups;
    traceStart = start;
    traceStop  = stop;
    tracePulse = pulse;
    timeTick   = (($urandom % 2) == 0);
    if (timeTick) begin
      tickTotal++;
    end
    bus = {groups[mSelHigh], groups[mSelLow]};
    cap = mEnable && ((mRun && !stop) || (start && !stop) || pulse);
    cap = cap && (!mChange || !mHaveLast || (bus != mLastBus));
    if (stop) begin
      mRun = 1'b0;
    end else if (start) begin
      mRun = 1'b1;
    end
    if (cap) begin
      expData.push_back(bus);
      mHaveLast = 1'b1;
      mLastBus  = bus;
    end
    @(posedge clk);
    #10;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
    timeTick   = 1'b0;
  endtask

  // Stop, then idle until the last entry reaches the buffer
  task automatic flushPipeline();
    driveCycle(randomGroups(1'b0), 1'b0, 1'b1, 1'b0);
    repeat (FLUSH_CYCLES) driveCycle(randomGroups(1'b0), 1'b0, 1'b0, 1'b0);
  endtask

  task automatic configure(input logic enable, input logic change, input logic wrap);
    logic [31:0] rd;
    logic        err;
    logic [3:0]  lo;
    logic [3:0]  hi;
    lo = 4'($urandom);
    hi = 4'($urandom);
    apbAccess(1'b1, REG_MUXSEL, {24'b0, hi, lo}, rd, err);
    apbAccess(1'b1, REG_CTRL, {28'b0, 1'b1, wrap, change, enable}, rd, err);
    mEnable   = enable;
    mChange   = change;
    mWrap     = wrap;
    mSelLow   = lo;
    mSelHigh  = hi;
    mRun      = 1'b0;
    mHaveLast = 1'b0;
    expData.delete();
  endtask

  // **************************************************
  // Buffer read-back against the model
  // **************************************************
  task automatic readBuffer(input string name);
    logic [31:0] rd;
    logic        err;
    int          n;
    int          expCount;
    int          first;
    logic [15:0] prevTs;
    logic [15:0] ts;
    n        = expData.size();
    expCount = (n > TRACE_DEPTH) ? TRACE_DEPTH : n;
    first    = (mWrap && (n > TRACE_DEPTH)) ? (n - TRACE_DEPTH) : 0;
    prevTs   = '0;
    apbAccess(1'b0, REG_STATUS, '0, rd, err);
    checkValue({name, " count"}, 32'(expCount), {25'b0, rd[6:0]});
    checkValue({name, " wrapped"}, 32'(mWrap && (n > TRACE_DEPTH)), {31'b0, rd[8]});
    for (int i = 0; i < expCount; i++) begin
      apbAccess(1'b1, REG_READIDX, 32'(i), rd, err);
      apbAccess(1'b0, REG_READDATA, '0, rd, err);
      checkValue($sformatf("%s data %0d", name, i), expData[first + i], rd);
      apbAccess(1'b0, REG_READTIME, '0, rd, err);
      ts = rd[15:0];
      checkValue($sformatf("%s valid %0d", name, i), 32'd1, {31'b0, rd[16]});
      checkValue($sformatf("%s time order %0d", name, i), 32'd1, 32'(ts >= prevTs));
      prevTs = ts;
    end
    if (expCount > 0) begin
      checkValue({name, " last time"}, 32'd1, 32'(int'(prevTs) <= tickTotal));
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    hwGroups_t   groups;
    errors     = 0;
    tickTotal  = 0;
    mEnable    = 1'b0;
    mChange    = 1'b0;
    mWrap      = 1'b0;
    mRun       = 1'b0;
    mHaveLast  = 1'b0;
    mLastBus   = '0;
    mSelLow    = '0;
    mSelHigh   = '0;
    reset      = 1'b1;
    hwGroups   = '0;
    traceStart = 1'b0;
    traceStop  = 1'b0;
    tracePulse = 1'b0;
    timeTick   = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    void'($urandom(32'h29f5));
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;

    // Register readback and slave errors
    apbAccess(1'b1, REG_CTRL, 32'h0000000F, rd, err);
    apbAccess(1'b0, REG_CTRL, '0, rd, err);
    checkValue("ctrl readback", 32'h7, rd);
    checkValue("ctrl slverr", 32'd0, {31'b0, err});
    apbAccess(1'b1, REG_MUXSEL, 32'h000000A5, rd, err);
    apbAccess(1'b0, REG_MUXSEL, '0, rd, err);
    checkValue("muxsel readback", 32'hA5, rd);
    apbAccess(1'b1, REG_READIDX, 32'h0000002A, rd, err);
    apbAccess(1'b0, REG_READIDX, '0, rd, err);
    checkValue("readidx readback", 32'h2A, rd);
    apbAccess(1'b0, 8'h20, '0, rd, err);
    checkValue("unmapped slverr", 32'd1, {31'b0, err});
    apbAccess(1'b1, REG_STATUS, 32'hFF, rd, err);
    checkValue("status write slverr", 32'd1, {31'b0, err});

    // Capture-all with random actions
    configure(1'b1, 1'b0, 1'b0);
    repeat (RANDOM_CYCLES) begin
      driveCycle(randomGroups(1'b0), ($urandom % 8) == 0, ($urandom % 10) == 0,
                 ($urandom % 6) == 0);
    end
    flushPipeline();
    readBuffer("capture all");

    // Change-only with a small value set
    configure(1'b1, 1'b1, 1'b0);
    groups = randomGroups(1'b1);
    driveCycle(groups, 1'b1, 1'b0, 1'b0);
    repeat (RANDOM_CYCLES - 1) begin
      if (($urandom % 3) == 0) begin
        groups = randomGroups(1'b1);
      end
      driveCycle(groups, 1'b0, 1'b0, 1'b0);
    end
    flushPipeline();
    readBuffer("change only");

    // Stop-when-full, then wrap
    configure(1'b1, 1'b0, 1'b0);
    repeat (FILL_SAMPLES) driveCycle(randomGroups(1'b0), 1'b0, 1'b0, 1'b1);
    flushPipeline();
    readBuffer("stop when full");
    configure(1'b1, 1'b0, 1'b1);
    repeat (FILL_SAMPLES) driveCycle(randomGroups(1'b0), 1'b0, 1'b0, 1'b1);
    flushPipeline();
    readBuffer("wrap");

    // Enable clear records nothing
    configure(1'b0, 1'b0, 1'b0);
    repeat (DISABLED_CYCLES) begin
      driveCycle(randomGroups(1'b0), ($urandom % 4) == 0, 1'b0, ($urandom % 3) == 0);
    end
    flushPipeline();
    readBuffer("disabled");

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

//--- vlog.f
rtl/dfd_pkg.sv
rtl/dfd_csr_regs.sv
rtl/dfd_debug_mux.sv
rtl/dfd_trace_ctrl.sv
rtl/dfd_packetizer.sv
rtl/dfd_trace_sink.sv
rtl/dfd_top.sv
tb/dfd_tb.sv
